// ==== include/mci_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Manageability controller constants
// Bus widths, MCU reset pulse length and register byte offsets
//////////////////////////////////////////////////////////////////////

`ifndef MCI_CONSTS_SVH
`define MCI_CONSTS_SVH

// Field widths
`define MCI_ADDR_W          8
`define MCI_DATA_W          32
`define MCI_CNT_W           32
`define MCI_ERR_W           32

// Cycles the MCU reset is held low on a software request
`define MCU_RST_CYCLES      16

// Register byte offsets
`define REG_BOOTFSM_GO      8'h00
`define REG_CPTRA_BOOT_GO   8'h04
`define REG_RESET_REQUEST   8'h08
`define REG_WDT_T1_EN       8'h0C
`define REG_WDT_T1_RESTART  8'h10
`define REG_WDT_T1_PERIOD   8'h14
`define REG_WDT_T2_PERIOD   8'h18
`define REG_WDT_STATUS      8'h1C
`define REG_ERR_FATAL_MASK  8'h20
`define REG_HW_ERR_FATAL    8'h24
`define REG_BOOT_STATUS     8'h28

`endif

// ==== logic/mci_boot_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Boot sequencer types
// State encoding and MCU reset pulse counter
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mci_consts.svh"

package mci_boot_pkg;

    // Encoding is visible through BOOT_STATUS
    typedef enum logic [2:0] {
        BOOT_IDLE    = 3'd0,
        BOOT_WAIT_GO = 3'd1,
        BOOT_LC_INIT = 3'd2,
        BOOT_FC_INIT = 3'd3,
        BOOT_MCU_RUN = 3'd4,
        BOOT_DONE    = 3'd5,
        BOOT_MCU_RST = 3'd6
    } boot_state_e;

    typedef logic [$clog2(`MCU_RST_CYCLES):0] rst_cnt_t;

endpackage

`default_nettype wire

// ==== logic/mci_boot_seqr.sv ====
//////////////////////////////////////////////////////////////////////
// Boot sequencer
// Breakpoint wait, LC and fuse init handshakes, MCU and Caliptra
// reset release, software MCU reset pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mci_consts.svh"

module mci_boot_seqr
    import mci_boot_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        brkpoint_i,
    input  logic        bootfsm_go_i,
    input  logic        cptra_go_i,
    input  logic        mcu_rst_req_i,

    input  logic        lc_done_i,
    input  logic        fc_opt_done_i,
    output logic        lc_init_o,
    output logic        fc_opt_init_o,

    output logic        mcu_rst_b_o,
    output logic        cptra_rst_b_o,
    output boot_state_e state_o
);

    boot_state_e state_q;
    boot_state_e state_d;
    rst_cnt_t    rst_cnt_q;
    logic        pulse_done;

    assign pulse_done = (rst_cnt_q == rst_cnt_t'(`MCU_RST_CYCLES - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_IDLE:    state_d = brkpoint_i ? BOOT_WAIT_GO : BOOT_LC_INIT;
            BOOT_WAIT_GO: if (bootfsm_go_i)  state_d = BOOT_LC_INIT;
            BOOT_LC_INIT: if (lc_done_i)     state_d = BOOT_FC_INIT;
            BOOT_FC_INIT: if (fc_opt_done_i) state_d = BOOT_MCU_RUN;
            BOOT_MCU_RUN: if (cptra_go_i)    state_d = BOOT_DONE;
            // Software reset request only honored once fully booted
            BOOT_DONE:    if (mcu_rst_req_i) state_d = BOOT_MCU_RST;
            BOOT_MCU_RST: if (pulse_done)    state_d = BOOT_DONE;
            default:      state_d = BOOT_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= BOOT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Counts cycles spent in BOOT_MCU_RST
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rst_cnt_q <= '0;
        end else if (state_q == BOOT_MCU_RST) begin
            rst_cnt_q <= rst_cnt_q + 1'b1;
        end else begin
            rst_cnt_q <= '0;
        end
    end

    // Outputs decoded from state
    assign lc_init_o     = (state_q == BOOT_LC_INIT);
    assign fc_opt_init_o = (state_q == BOOT_FC_INIT);
    assign mcu_rst_b_o   = (state_q == BOOT_MCU_RUN) || (state_q == BOOT_DONE);
    assign cptra_rst_b_o = (state_q == BOOT_DONE) || (state_q == BOOT_MCU_RST);
    assign state_o       = state_q;

endmodule

`default_nettype wire

// ==== logic/mci_reg_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Register-side types
// Address, data word, watchdog count and fatal error vector
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mci_consts.svh"

package mci_reg_pkg;

    typedef logic [`MCI_ADDR_W-1:0] reg_addr_t;
    typedef logic [`MCI_DATA_W-1:0] reg_data_t;

    // Timer count or timeout period
    typedef logic [`MCI_CNT_W-1:0]  wdt_count_t;

    // One bit per aggregated fatal source
    typedef logic [`MCI_ERR_W-1:0]  err_vec_t;

endpackage

`default_nettype wire

// ==== logic/mci_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Register bank
// Write decode, read mux, watchdog status, fatal error aggregation
// and interrupt outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mci_consts.svh"

module mci_regs
    import mci_reg_pkg::*;
    import mci_boot_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        wr_en_i,
    input  reg_addr_t   addr_i,
    input  reg_data_t   wdata_i,
    output reg_data_t   rdata_o,

    input  err_vec_t    agg_error_fatal_i,
    input  boot_state_e boot_state_i,

    output logic        bootfsm_go_o,
    output logic        cptra_go_o,
    output logic        mcu_rst_req_o,

    output logic        all_error_fatal_o,
    output logic        mci_intr_o,
    output logic        nmi_intr_o,

    mci_wdt_if.regs     wdt
);

    logic       bootfsm_go_q;
    logic       cptra_go_q;
    logic       mcu_rst_req_q;
    logic       t1_en_q;
    wdt_count_t t1_period_q;
    wdt_count_t t2_period_q;
    err_vec_t   err_mask_q;
    err_vec_t   hw_err_q;
    logic       t1_sts_q;
    logic       t2_sts_q;

    logic       status_w1c;
    err_vec_t   err_w1c;

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    // Restart and service act on the write edge itself
    assign wdt.t1_restart = wr_en_i && (addr_i == `REG_WDT_T1_RESTART) && wdata_i[0];
    assign status_w1c     = wr_en_i && (addr_i == `REG_WDT_STATUS) && wdata_i[0];
    assign err_w1c        = (wr_en_i && (addr_i == `REG_HW_ERR_FATAL)) ?
                            err_vec_t'(wdata_i) : '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bootfsm_go_q  <= 1'b0;
            cptra_go_q    <= 1'b0;
            mcu_rst_req_q <= 1'b0;
            t1_en_q       <= 1'b0;
            t1_period_q   <= '0;
            t2_period_q   <= '0;
            err_mask_q    <= '0;
        end else begin
            // Request reaches the sequencer one edge after the write
            mcu_rst_req_q <= wr_en_i && (addr_i == `REG_RESET_REQUEST) && wdata_i[0];
            if (wr_en_i) begin
                case (addr_i)
                    `REG_BOOTFSM_GO:     bootfsm_go_q <= wdata_i[0];
                    `REG_CPTRA_BOOT_GO:  cptra_go_q   <= wdata_i[0];
                    `REG_WDT_T1_EN:      t1_en_q      <= wdata_i[0];
                    `REG_WDT_T1_PERIOD:  t1_period_q  <= wdt_count_t'(wdata_i);
                    `REG_WDT_T2_PERIOD:  t2_period_q  <= wdt_count_t'(wdata_i);
                    `REG_ERR_FATAL_MASK: err_mask_q   <= err_vec_t'(wdata_i);
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sticky status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            t1_sts_q <= 1'b0;
            t2_sts_q <= 1'b0;
            hw_err_q <= '0;
        end else begin
            // A new expiry wins over a service in the same cycle
            if (wdt.t1_expire) begin
                t1_sts_q <= 1'b1;
            end else if (status_w1c) begin
                t1_sts_q <= 1'b0;
            end
            // NMI status only clears on reset
            if (wdt.t2_expire) begin
                t2_sts_q <= 1'b1;
            end
            hw_err_q <= (hw_err_q & ~err_w1c) | agg_error_fatal_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read mux and outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rdata_o = '0;
        case (addr_i)
            `REG_BOOTFSM_GO:     rdata_o = reg_data_t'(bootfsm_go_q);
            `REG_CPTRA_BOOT_GO:  rdata_o = reg_data_t'(cptra_go_q);
            `REG_WDT_T1_EN:      rdata_o = reg_data_t'(t1_en_q);
            `REG_WDT_T1_PERIOD:  rdata_o = reg_data_t'(t1_period_q);
            `REG_WDT_T2_PERIOD:  rdata_o = reg_data_t'(t2_period_q);
            `REG_WDT_STATUS:     rdata_o = reg_data_t'({t2_sts_q, t1_sts_q});
            `REG_ERR_FATAL_MASK: rdata_o = reg_data_t'(err_mask_q);
            `REG_HW_ERR_FATAL:   rdata_o = reg_data_t'(hw_err_q);
            `REG_BOOT_STATUS:    rdata_o = reg_data_t'(boot_state_i);
            default:             rdata_o = '0;
        endcase
    end

    assign wdt.t1_en       = t1_en_q;
    assign wdt.t1_period   = t1_period_q;
    assign wdt.t2_period   = t2_period_q;
    assign wdt.t1_serviced = status_w1c;

    assign bootfsm_go_o      = bootfsm_go_q;
    assign cptra_go_o        = cptra_go_q;
    assign mcu_rst_req_o     = mcu_rst_req_q;
    assign all_error_fatal_o = |(hw_err_q & ~err_mask_q);
    assign mci_intr_o        = t1_sts_q;
    assign nmi_intr_o        = t2_sts_q;

endmodule

`default_nettype wire

// ==== logic/mci_top.sv ====
//////////////////////////////////////////////////////////////////////
// Manageability controller top level
// Register bank, boot sequencer and watchdog on plain ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mci_top
    import mci_reg_pkg::*;
    import mci_boot_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Register port
    input  logic      reg_wr_en_i,
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_wdata_i,
    output reg_data_t reg_rdata_o,

    // Boot handshakes
    input  logic      brkpoint_i,
    input  logic      lc_done_i,
    input  logic      fc_opt_done_i,
    output logic      lc_init_o,
    output logic      fc_opt_init_o,

    // Reset controls
    output logic      mcu_rst_b_o,
    output logic      cptra_rst_b_o,

    // Errors and interrupts
    input  err_vec_t  agg_error_fatal_i,
    output logic      all_error_fatal_o,
    output logic      mci_intr_o,
    output logic      nmi_intr_o
);

    logic        bootfsm_go;
    logic        cptra_go;
    logic        mcu_rst_req;
    boot_state_e boot_state;

    mci_wdt_if wdt_if ();

    mci_regs i_mci_regs (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .wr_en_i           (reg_wr_en_i),
        .addr_i            (reg_addr_i),
        .wdata_i           (reg_wdata_i),
        .rdata_o           (reg_rdata_o),
        .agg_error_fatal_i (agg_error_fatal_i),
        .boot_state_i      (boot_state),
        .bootfsm_go_o      (bootfsm_go),
        .cptra_go_o        (cptra_go),
        .mcu_rst_req_o     (mcu_rst_req),
        .all_error_fatal_o (all_error_fatal_o),
        .mci_intr_o        (mci_intr_o),
        .nmi_intr_o        (nmi_intr_o),
        .wdt               (wdt_if.regs)
    );

    mci_boot_seqr i_boot_seqr (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .brkpoint_i    (brkpoint_i),
        .bootfsm_go_i  (bootfsm_go),
        .cptra_go_i    (cptra_go),
        .mcu_rst_req_i (mcu_rst_req),
        .lc_done_i     (lc_done_i),
        .fc_opt_done_i (fc_opt_done_i),
        .lc_init_o     (lc_init_o),
        .fc_opt_init_o (fc_opt_init_o),
        .mcu_rst_b_o   (mcu_rst_b_o),
        .cptra_rst_b_o (cptra_rst_b_o),
        .state_o       (boot_state)
    );

    mci_wdt i_mci_wdt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ctl     (wdt_if.wdt)
    );

endmodule

`default_nettype wire

// ==== logic/mci_wdt.sv ====
//////////////////////////////////////////////////////////////////////
// Cascaded watchdog
// Timer 1 runs while enabled, timer 2 runs while timer 1 has
// expired and is not serviced
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mci_wdt
    import mci_reg_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    mci_wdt_if.wdt  ctl
);

    wdt_count_t t1_cnt_q;
    wdt_count_t t2_cnt_q;
    logic       t1_fired_q;
    logic       t1_hit;
    logic       t2_hit;

    assign t1_hit = ctl.t1_en && (t1_cnt_q == ctl.t1_period);
    assign t2_hit = t1_fired_q && (t2_cnt_q == ctl.t2_period);

    assign ctl.t1_expire = t1_hit;
    assign ctl.t2_expire = t2_hit;

    //////////////////////////////////////////////////////////////////////
    // Timer 1
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            t1_cnt_q <= '0;
        end else if (!ctl.t1_en || ctl.t1_restart || t1_hit) begin
            t1_cnt_q <= '0;
        end else begin
            t1_cnt_q <= t1_cnt_q + 1'b1;
        end
    end

    // Local copy of timer 1 status, tracks the register bank
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            t1_fired_q <= 1'b0;
        end else if (t1_hit) begin
            t1_fired_q <= 1'b1;
        end else if (ctl.t1_serviced) begin
            t1_fired_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Timer 2
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            t2_cnt_q <= '0;
        end else if (!t1_fired_q || ctl.t1_serviced || t2_hit) begin
            t2_cnt_q <= '0;
        end else begin
            t2_cnt_q <= t2_cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mci_wdt_if.sv ====
//////////////////////////////////////////////////////////////////////
// Watchdog control and status bundle
// Register bank side drives controls, watchdog side drives expiries
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface mci_wdt_if import mci_reg_pkg::*; ();

    logic       t1_en;
    logic       t1_restart;
    wdt_count_t t1_period;
    wdt_count_t t2_period;
    logic       t1_serviced;

    // Single-cycle pulses, status is held in the register bank
    logic       t1_expire;
    logic       t2_expire;

    modport regs (
        output t1_en, t1_restart, t1_period, t2_period, t1_serviced,
        input  t1_expire, t2_expire
    );

    modport wdt (
        input  t1_en, t1_restart, t1_period, t2_period, t1_serviced,
        output t1_expire, t2_expire
    );

endinterface

`default_nettype wire

// ==== sim.f ====
+incdir+include
logic/mci_reg_pkg.sv
logic/mci_boot_pkg.sv
logic/mci_wdt_if.sv
logic/mci_regs.sv
logic/mci_boot_seqr.sv
logic/mci_wdt.sv
logic/mci_top.sv
tests/mci_checker.sv
tests/mci_tb.sv

// ==== tests/mci_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the controller's top-level outputs
// Init handshake exclusion, reset release order, sticky NMI and
// output state during reset, bound to the top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mci_checker (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic lc_init_i,
    input  logic fc_opt_init_i,
    input  logic mcu_rst_b_i,
    input  logic cptra_rst_b_i,
    input  logic all_error_fatal_i,
    input  logic mci_intr_i,
    input  logic nmi_intr_i
);

    // Assertion failures seen so far
    int unsigned fail_count = 0;

    // Only one init handshake at a time
    init_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(lc_init_i && fc_opt_init_i))
        else begin
            $error("lc_init and fc_opt_init high together");
            fail_count++;
        end

    // Caliptra comes out of reset only behind the MCU
    cptra_after_mcu_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(cptra_rst_b_i) |-> mcu_rst_b_i)
        else begin
            $error("cptra_rst_b rose while mcu_rst_b low");
            fail_count++;
        end

    nmi_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        nmi_intr_i |=> nmi_intr_i)
        else begin
            $error("nmi_intr dropped without reset");
            fail_count++;
        end

    // Synchronous reset, outputs settle one edge later
    reset_quiet_a: assert property (@(posedge clk_i)
        !rst_n_i |=> !(lc_init_i || fc_opt_init_i || mcu_rst_b_i || cptra_rst_b_i ||
                       all_error_fatal_i || mci_intr_i || nmi_intr_i))
        else begin
            $error("control output high during reset");
            fail_count++;
        end

endmodule

bind mci_top mci_checker checker_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .lc_init_i         (lc_init_o),
    .fc_opt_init_i     (fc_opt_init_o),
    .mcu_rst_b_i       (mcu_rst_b_o),
    .cptra_rst_b_i     (cptra_rst_b_o),
    .all_error_fatal_i (all_error_fatal_o),
    .mci_intr_i        (mci_intr_o),
    .nmi_intr_i        (nmi_intr_o)
);

`default_nettype wire

// ==== tests/mci_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Controller testbench
// Clock and reset, stimulus table with its runner, LCG for the
// handshake delays, value check and run timeout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mci_consts.svh"

module mci_tb
    import mci_reg_pkg::*;
    import mci_boot_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 16;
    localparam int T1_P       = 5;
    localparam int T2_P       = 3;

    // Table operations
    localparam int OP_WR       = 0;
    localparam int OP_RD       = 1;
    localparam int OP_SET      = 2;
    localparam int OP_WAIT     = 3;
    localparam int OP_WAIT_RND = 4;
    localparam int OP_WAIT_OUT = 5;

    localparam int IN_RST      = 0;
    localparam int IN_BRK      = 1;
    localparam int IN_LC_DONE  = 2;
    localparam int IN_FC_DONE  = 3;
    localparam int IN_ERR      = 4;

    localparam int OUT_LC      = 0;
    localparam int OUT_FC      = 1;
    localparam int OUT_MCU     = 2;
    localparam int OUT_CPTRA   = 3;
    localparam int OUT_ERR     = 4;
    localparam int OUT_MCI     = 5;
    localparam int OUT_NMI     = 6;

    // sel is a register offset or a signal id, lim bounds an output wait
    typedef struct packed {
        logic [3:0]  op;
        logic [7:0]  sel;
        logic [31:0] val;
        logic [15:0] lim;
    } step_t;

    logic      clk;
    logic      rst_n;
    logic      reg_wr_en;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    logic      brkpoint;
    logic      lc_done;
    logic      fc_opt_done;
    err_vec_t  agg_error_fatal;
    logic      lc_init;
    logic      fc_opt_init;
    logic      mcu_rst_b;
    logic      cptra_rst_b;
    logic      all_error_fatal;
    logic      mci_intr;
    logic      nmi_intr;

    step_t       steps[$];
    bit          table_ready;
    logic [31:0] lcg_state;

    mci_top dut_i (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .reg_wr_en_i       (reg_wr_en),
        .reg_addr_i        (reg_addr),
        .reg_wdata_i       (reg_wdata),
        .reg_rdata_o       (reg_rdata),
        .brkpoint_i        (brkpoint),
        .lc_done_i         (lc_done),
        .fc_opt_done_i     (fc_opt_done),
        .lc_init_o         (lc_init),
        .fc_opt_init_o     (fc_opt_init),
        .mcu_rst_b_o       (mcu_rst_b),
        .cptra_rst_b_o     (cptra_rst_b),
        .agg_error_fatal_i (agg_error_fatal),
        .all_error_fatal_o (all_error_fatal),
        .mci_intr_o        (mci_intr),
        .nmi_intr_o        (nmi_intr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic output_level(input int sel);
        case (sel)
            OUT_LC:    return lc_init;
            OUT_FC:    return fc_opt_init;
            OUT_MCU:   return mcu_rst_b;
            OUT_CPTRA: return cptra_rst_b;
            OUT_ERR:   return all_error_fatal;
            OUT_MCI:   return mci_intr;
            default:   return nmi_intr;
        endcase
    endfunction

    function automatic string output_name(input int sel);
        case (sel)
            OUT_LC:    return "lc_init_o";
            OUT_FC:    return "fc_opt_init_o";
            OUT_MCU:   return "mcu_rst_b_o";
            OUT_CPTRA: return "cptra_rst_b_o";
            OUT_ERR:   return "all_error_fatal_o";
            OUT_MCI:   return "mci_intr_o";
            default:   return "nmi_intr_o";
        endcase
    endfunction

    // Worst-case cycles a row can take
    function automatic int step_cycles(input step_t s);
        case (s.op)
            OP_WR, OP_RD:         return 1;
            OP_WAIT, OP_WAIT_RND: return int'(s.val);
            OP_WAIT_OUT:          return int'(s.lim);
            default:              return 0;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp) begin
            $display("Mismatch %s exp=%h got=%h", name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic drive_input(input int sel, input logic [31:0] val);
        case (sel)
            IN_RST:     rst_n = val[0];
            IN_BRK:     brkpoint = val[0];
            IN_LC_DONE: lc_done = val[0];
            IN_FC_DONE: fc_opt_done = val[0];
            IN_ERR:     agg_error_fatal = err_vec_t'(val);
            default: ;
        endcase
    endtask

    task automatic add_step(input int op, input int sel, input logic [31:0] val,
                            input int lim);
        steps.push_back('{op: op[3:0], sel: sel[7:0], val: val, lim: lim[15:0]});
    endtask

    task automatic write_reg(input int addr, input logic [31:0] data);
        add_step(OP_WR, addr, data, 0);
    endtask

    task automatic read_expect(input int addr, input logic [31:0] exp);
        add_step(OP_RD, addr, exp, 0);
    endtask

    task automatic set_input(input int sel, input logic [31:0] val);
        add_step(OP_SET, sel, val, 0);
    endtask

    task automatic wait_cycles(input int n);
        add_step(OP_WAIT, 0, n, 0);
    endtask

    // Delay of 0 up to mask cycles, drawn from the LCG
    task automatic wait_random(input int mask);
        add_step(OP_WAIT_RND, 0, mask, 0);
    endtask

    // A limit of 0 checks the level right away
    task automatic expect_output(input int sel, input logic level, input int lim);
        add_step(OP_WAIT_OUT, sel, level, lim);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic build_table();
        // Boot order
        expect_output(OUT_LC, 0, 0);
        expect_output(OUT_MCU, 0, 0);
        expect_output(OUT_CPTRA, 0, 0);
        expect_output(OUT_LC, 1, 4);
        wait_random(7);
        expect_output(OUT_LC, 1, 0);
        expect_output(OUT_FC, 0, 0);
        set_input(IN_LC_DONE, 1);
        wait_cycles(1);
        set_input(IN_LC_DONE, 0);
        expect_output(OUT_LC, 0, 0);
        expect_output(OUT_FC, 1, 0);
        wait_random(7);
        expect_output(OUT_FC, 1, 0);
        expect_output(OUT_MCU, 0, 0);
        set_input(IN_FC_DONE, 1);
        wait_cycles(1);
        set_input(IN_FC_DONE, 0);
        expect_output(OUT_FC, 0, 0);
        expect_output(OUT_MCU, 1, 0);
        read_expect(`REG_BOOT_STATUS, BOOT_MCU_RUN);
        wait_cycles(4);
        expect_output(OUT_CPTRA, 0, 0);
        write_reg(`REG_CPTRA_BOOT_GO, 1);
        expect_output(OUT_CPTRA, 0, 0);
        wait_cycles(1);
        expect_output(OUT_CPTRA, 1, 0);
        read_expect(`REG_BOOT_STATUS, BOOT_DONE);

        // MCU reset pulse, request lands one edge after the write
        write_reg(`REG_RESET_REQUEST, 1);
        expect_output(OUT_MCU, 1, 0);
        wait_cycles(1);
        expect_output(OUT_MCU, 0, 0);
        expect_output(OUT_CPTRA, 1, 0);
        // Checked on every cycle of the pulse
        repeat (`MCU_RST_CYCLES - 1) begin
            wait_cycles(1);
            expect_output(OUT_MCU, 0, 0);
            expect_output(OUT_CPTRA, 1, 0);
        end
        wait_cycles(1);
        expect_output(OUT_MCU, 1, 0);
        read_expect(`REG_RESET_REQUEST, 0);

        // Fatal error aggregation, upper nibble masked
        write_reg(`REG_ERR_FATAL_MASK, 32'h0000_00f0);
        set_input(IN_ERR, 32'h0000_0011);
        expect_output(OUT_ERR, 0, 0);
        wait_cycles(1);
        set_input(IN_ERR, 0);
        expect_output(OUT_ERR, 1, 0);
        read_expect(`REG_HW_ERR_FATAL, 32'h0000_0011);
        write_reg(`REG_HW_ERR_FATAL, 32'h0000_0001);
        expect_output(OUT_ERR, 0, 0);
        read_expect(`REG_HW_ERR_FATAL, 32'h0000_0010);
        set_input(IN_ERR, 32'h0000_0020);
        wait_cycles(1);
        set_input(IN_ERR, 0);
        expect_output(OUT_ERR, 0, 0);
        write_reg(`REG_HW_ERR_FATAL, 32'h0000_0030);
        read_expect(`REG_HW_ERR_FATAL, 0);

        // Watchdog serviced in time
        write_reg(`REG_WDT_T1_PERIOD, T1_P);
        write_reg(`REG_WDT_T2_PERIOD, T2_P);
        write_reg(`REG_WDT_T1_EN, 1);
        wait_cycles(T1_P);
        expect_output(OUT_MCI, 0, 0);
        wait_cycles(1);
        expect_output(OUT_MCI, 1, 0);
        write_reg(`REG_WDT_STATUS, 1);
        expect_output(OUT_MCI, 0, 0);
        write_reg(`REG_WDT_T1_EN, 0);
        wait_cycles(T2_P + 4);
        expect_output(OUT_NMI, 0, 0);
        expect_output(OUT_MCI, 0, 0);

        // Restart pushes timer 1 out, then left unserviced
        write_reg(`REG_WDT_T1_EN, 1);
        wait_cycles(3);
        write_reg(`REG_WDT_T1_RESTART, 1);
        wait_cycles(2);
        expect_output(OUT_MCI, 0, 0);
        wait_cycles(T1_P - 2);
        expect_output(OUT_MCI, 0, 0);
        wait_cycles(1);
        expect_output(OUT_MCI, 1, 0);
        wait_cycles(T2_P);
        expect_output(OUT_NMI, 0, 0);
        wait_cycles(1);
        expect_output(OUT_NMI, 1, 0);
        wait_cycles(5);
        expect_output(OUT_NMI, 1, 0);
        read_expect(`REG_WDT_STATUS, 32'h0000_0003);

        // Second reset with the breakpoint held
        set_input(IN_RST, 0);
        set_input(IN_BRK, 1);
        wait_cycles(RST_CYCLES);
        set_input(IN_RST, 1);
        expect_output(OUT_NMI, 0, 0);
        expect_output(OUT_MCI, 0, 0);
        expect_output(OUT_CPTRA, 0, 0);
        wait_cycles(1);
        read_expect(`REG_BOOT_STATUS, BOOT_WAIT_GO);
        wait_cycles(4);
        expect_output(OUT_LC, 0, 0);
        write_reg(`REG_BOOTFSM_GO, 1);
        expect_output(OUT_LC, 0, 0);
        expect_output(OUT_LC, 1, 2);
        set_input(IN_BRK, 0);
    endtask

    // Each row starts and ends on a falling edge
    task automatic run_step(input step_t s);
        int n;
        case (s.op)
            OP_WR: begin
                reg_wr_en = 1'b1;
                reg_addr  = reg_addr_t'(s.sel);
                reg_wdata = s.val;
                @(negedge clk);
                reg_wr_en = 1'b0;
            end
            OP_RD: begin
                reg_addr = reg_addr_t'(s.sel);
                #1;
                check_value($sformatf("reg_rdata_o@%h", s.sel), s.val, reg_rdata);
                @(negedge clk);
            end
            OP_SET: drive_input(s.sel, s.val);
            OP_WAIT: repeat (s.val) @(negedge clk);
            OP_WAIT_RND: begin
                lcg_state = lcg_next(lcg_state);
                n = int'((lcg_state >> 16) & s.val);
                repeat (n) @(negedge clk);
            end
            OP_WAIT_OUT: begin
                if (s.lim == 0) begin
                    check_value(output_name(s.sel), s.val, output_level(s.sel));
                end else begin
                    n = 0;
                    while (output_level(s.sel) !== s.val[0] && n < s.lim) begin
                        @(negedge clk);
                        n++;
                    end
                    if (output_level(s.sel) !== s.val[0]) begin
                        $display("%s did not reach %0d within %0d cycles",
                                 output_name(s.sel), s.val[0], s.lim);
                        stop_with_failure();
                    end
                end
            end
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and timeout
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        reg_wr_en       = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        brkpoint        = 1'b0;
        lc_done         = 1'b0;
        fc_opt_done     = 1'b0;
        agg_error_fatal = '0;
        lcg_state       = 32'h9eebc813;
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        if (dut_i.checker_i.fail_count != 0) begin
            $display("%0d assertions in the bound checker failed",
                     dut_i.checker_i.fail_count);
            stop_with_failure();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    initial begin
        longint total;
        wait (table_ready);
        total = RST_CYCLES + 64;
        foreach (steps[i]) begin
            total += step_cycles(steps[i]);
        end
        #(total * CLK_PERIOD);
        $display("Timeout after %0d cycles, stimulus table did not complete", total);
        stop_with_failure();
    end

endmodule

`default_nettype wire
